// ==== include/lsu_settings.svh ====
// ****************************
// LSU build constants
// ****************************

`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Datapath
`define LSU_DATA_W       32             // Data and address width
`define LSU_BYTE_W       4              // Byte enables per word

// DCCM window
// Window size is 2^(LSU_DCCM_ADDR_W+2) bytes
`define LSU_DCCM_BASE    32'hF004_0000  // Window base, aligned to window size
`define LSU_DCCM_ADDR_W  10             // Word address bits, 4 KiB

// Store buffer
`define LSU_STBUF_DEPTH  4              // Entries, power of two
`define LSU_STBUF_IDX_W  2              // Pointer width, log2 of depth

`endif

// ==== hw/lsu_pkg.sv ====
// ****************************
// LSU shared types
// ****************************

`include "lsu_settings.svh"

package lsu_pkg;

   typedef enum logic {
      LSU_LOAD  = 1'b0,
      LSU_STORE = 1'b1
   } lsu_op_e;

   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } lsu_size_e;

   typedef enum logic [1:0] {
      EXC_NONE       = 2'd0,
      EXC_MISALIGNED = 2'd1,
      EXC_ACCESS     = 2'd2   // Outside the DCCM window
   } lsu_exc_e;

   // Request as it enters dc1
   typedef struct packed {
      logic      valid;
      lsu_op_e   op;
      lsu_size_e size;
      logic      unsign;      // Zero extend on load
   } lsu_pkt_t;

   // One pipeline stage
   typedef struct packed {
      lsu_pkt_t               pkt;
      logic [`LSU_DATA_W-1:0] addr;
      logic [`LSU_DATA_W-1:0] data;        // Unshifted store data
      logic                   in_dccm;
      logic                   misaligned;
   } lsu_stage_t;

   typedef struct packed {
      logic                   exc_valid;
      lsu_exc_e               exc_type;
      logic [`LSU_DATA_W-1:0] addr;
   } lsu_error_pkt_t;

   // Store buffer bytes for the dc2 load
   typedef struct packed {
      logic [`LSU_BYTE_W-1:0] byteen;
      logic [`LSU_DATA_W-1:0] data;
   } lsu_fwd_t;

endpackage

// ==== hw/lsu_lsc_ctl.sv ====
// ****************************
// LSU address and pipe control
// ****************************

`timescale 1ns/100ps
`include "lsu_settings.svh"

module lsu_lsc_ctl (
   input  logic                    clk,
   input  logic                    arst_n,
   input  lsu_pkg::lsu_pkt_t       lsu_p,             // Request packet, dc1
   input  logic [`LSU_DATA_W-1:0]  rs1,               // Base register
   input  logic [11:0]             offset,            // Signed immediate
   input  logic [`LSU_DATA_W-1:0]  store_data,
   output lsu_pkg::lsu_stage_t     stage_dc1,
   output lsu_pkg::lsu_stage_t     stage_dc2,
   output lsu_pkg::lsu_stage_t     stage_dc3,
   output lsu_pkg::lsu_error_pkt_t lsu_error_pkt_dc3
);

   localparam int WIN_LSB = `LSU_DCCM_ADDR_W + 2;             // Lowest bit above the window
   localparam logic [`LSU_DATA_W-1:0] DCCM_BASE = `LSU_DCCM_BASE;

   logic [`LSU_DATA_W-1:0] addr_dc1;
   logic                   in_dccm_dc1;
   logic                   misaligned_dc1;
   logic                   valid_dc2;
   logic                   valid_dc3;
   lsu_pkg::lsu_stage_t    pay_dc2;
   lsu_pkg::lsu_stage_t    pay_dc3;
   logic                   exc_dc3;

   // ****************************
   // dc1 address and checks
   // ****************************
   assign addr_dc1    = rs1 + {{(`LSU_DATA_W-12){offset[11]}}, offset};
   assign in_dccm_dc1 = addr_dc1[`LSU_DATA_W-1:WIN_LSB] == DCCM_BASE[`LSU_DATA_W-1:WIN_LSB];

   always_comb begin
      case (lsu_p.size)
         lsu_pkg::SZ_HALF: misaligned_dc1 = addr_dc1[0];
         lsu_pkg::SZ_WORD: misaligned_dc1 = |addr_dc1[1:0];
         default:          misaligned_dc1 = 1'b0;           // Bytes are always aligned
      endcase
   end

   assign stage_dc1 = '{pkt: lsu_p, addr: addr_dc1, data: store_data,
                        in_dccm: in_dccm_dc1, misaligned: misaligned_dc1};

   // ****************************
   // dc2 and dc3 flops
   // ****************************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_dc2 <= 1'b0;
         valid_dc3 <= 1'b0;
      end else begin
         valid_dc2 <= stage_dc1.pkt.valid;
         valid_dc3 <= valid_dc2;
      end
   end

   always_ff @(posedge clk) begin
      pay_dc2 <= stage_dc1;
      pay_dc3 <= pay_dc2;
   end

   // Valid bits come from the reset flops
   always_comb begin
      stage_dc2           = pay_dc2;
      stage_dc2.pkt.valid = valid_dc2;
      stage_dc3           = pay_dc3;
      stage_dc3.pkt.valid = valid_dc3;
   end

   // Error report, misaligned takes priority over access fault
   assign exc_dc3 = stage_dc3.pkt.valid & (stage_dc3.misaligned | ~stage_dc3.in_dccm);

   always_comb begin
      lsu_error_pkt_dc3.exc_valid = exc_dc3;
      lsu_error_pkt_dc3.addr      = stage_dc3.addr;
      if (!exc_dc3)                  lsu_error_pkt_dc3.exc_type = lsu_pkg::EXC_NONE;
      else if (stage_dc3.misaligned) lsu_error_pkt_dc3.exc_type = lsu_pkg::EXC_MISALIGNED;
      else                           lsu_error_pkt_dc3.exc_type = lsu_pkg::EXC_ACCESS;
   end

   // Size 3 is reserved, the alignment check above treats it as a byte
   a_size_legal: assert property (@(posedge clk) disable iff (!arst_n)
      lsu_p.valid |-> (lsu_p.size != 2'd3));

endmodule

// ==== hw/lsu_stbuf.sv ====
// ****************************
// LSU store buffer
// ****************************

`timescale 1ns/100ps
`include "lsu_settings.svh"

module lsu_stbuf (
   input  logic                        clk,
   input  logic                        arst_n,
   input  lsu_pkg::lsu_stage_t         stage_dc2,
   input  logic                        dccm_rden,        // Load owns the port this cycle
   output logic [`LSU_DCCM_ADDR_W-1:0] stbuf_wr_addr,
   output logic [`LSU_DATA_W-1:0]      stbuf_wr_data,
   output logic [`LSU_BYTE_W-1:0]      stbuf_wr_byteen,
   output logic                        stbuf_drain,      // Head is written this cycle
   output lsu_pkg::lsu_fwd_t           fwd_dc2,
   output logic                        lsu_store_stall_any,
   output logic                        stbuf_empty
);

   localparam int IDX_W  = `LSU_STBUF_IDX_W;
   localparam int AW     = `LSU_DCCM_ADDR_W;
   localparam int BYTE_W = `LSU_BYTE_W;
   localparam logic [IDX_W:0] DEPTH = `LSU_STBUF_DEPTH;

   // Entry storage, no reset
   logic [AW-1:0]          ent_addr   [`LSU_STBUF_DEPTH];
   logic [BYTE_W-1:0]      ent_byteen [`LSU_STBUF_DEPTH];
   logic [`LSU_DATA_W-1:0] ent_data   [`LSU_STBUF_DEPTH];

   logic [IDX_W-1:0]       wr_ptr;
   logic [IDX_W-1:0]       rd_ptr;
   logic [IDX_W:0]         count;
   logic                   alloc;
   logic                   ld_dc2;
   logic [AW-1:0]          waddr_dc2;
   logic [BYTE_W-1:0]      byteen_dc2;
   logic [IDX_W-1:0]       fwd_idx;

   assign waddr_dc2 = stage_dc2.addr[AW+1:2];

   // Legal stores only, errors never enter
   assign alloc  = stage_dc2.pkt.valid & (stage_dc2.pkt.op == lsu_pkg::LSU_STORE) &
                   stage_dc2.in_dccm & ~stage_dc2.misaligned;
   assign ld_dc2 = stage_dc2.pkt.valid & (stage_dc2.pkt.op == lsu_pkg::LSU_LOAD) &
                   stage_dc2.in_dccm;

   always_comb begin
      case (stage_dc2.pkt.size)
         lsu_pkg::SZ_BYTE: byteen_dc2 = BYTE_W'(1) << stage_dc2.addr[1:0];
         lsu_pkg::SZ_HALF: byteen_dc2 = BYTE_W'(3) << stage_dc2.addr[1:0];
         default:          byteen_dc2 = '1;
      endcase
   end

   // ****************************
   // Allocate and drain
   // ****************************
   always_ff @(posedge clk) begin
      if (alloc) begin
         ent_addr[wr_ptr]   <= waddr_dc2;
         ent_byteen[wr_ptr] <= byteen_dc2;
         ent_data[wr_ptr]   <= stage_dc2.data << {stage_dc2.addr[1:0], 3'b000};  // Lane aligned
      end
   end

   assign stbuf_drain     = (count != '0) & ~dccm_rden;  // Only when no load reads
   assign stbuf_wr_addr   = ent_addr[rd_ptr];
   assign stbuf_wr_data   = ent_data[rd_ptr];
   assign stbuf_wr_byteen = ent_byteen[rd_ptr];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (alloc)       wr_ptr <= wr_ptr + 1'b1;
         if (stbuf_drain) rd_ptr <= rd_ptr + 1'b1;         // Entry leaves after its write
         count <= count + {{IDX_W{1'b0}}, alloc} - {{IDX_W{1'b0}}, stbuf_drain};
      end
   end

   // Two stores may already sit in dc1 and dc2
   assign lsu_store_stall_any = (DEPTH - count) < 2;
   assign stbuf_empty         = (count == '0);

   // ****************************
   // Load forwarding
   // ****************************
   // Walk oldest to newest so younger bytes overwrite older ones
   always_comb begin
      fwd_dc2 = '0;
      fwd_idx = rd_ptr;
      for (int i = 0; i < `LSU_STBUF_DEPTH; i++) begin
         fwd_idx = rd_ptr + IDX_W'(i);
         if (ld_dc2 && (i < count) && (ent_addr[fwd_idx] == waddr_dc2)) begin
            for (int b = 0; b < BYTE_W; b++) begin
               if (ent_byteen[fwd_idx][b]) begin
                  fwd_dc2.byteen[b]      = 1'b1;
                  fwd_dc2.data[8*b +: 8] = ent_data[fwd_idx][8*b +: 8];
               end
            end
         end
      end
   end

   // Stall must have held the source off before the buffer filled
   a_no_alloc_full: assert property (@(posedge clk) disable iff (!arst_n)
      alloc |-> (count != DEPTH));

   // Pointers agree with count whenever an entry is written out
   a_drain_has_entry: assert property (@(posedge clk) disable iff (!arst_n)
      stbuf_drain |-> ((wr_ptr != rd_ptr) || (count == DEPTH)) ##1 (count <= DEPTH));

endmodule

// ==== hw/lsu_dccm_ctl.sv ====
// ****************************
// LSU DCCM port and load data
// ****************************

`timescale 1ns/100ps
`include "lsu_settings.svh"

module lsu_dccm_ctl (
   input  logic                        clk,
   input  logic                        arst_n,
   input  lsu_pkg::lsu_stage_t         stage_dc1,
   input  lsu_pkg::lsu_stage_t         stage_dc2,
   input  logic [`LSU_DATA_W-1:0]      dccm_rd_data,     // Valid in dc2
   input  lsu_pkg::lsu_fwd_t           fwd_dc2,
   input  logic [`LSU_DCCM_ADDR_W-1:0] stbuf_wr_addr,
   input  logic [`LSU_DATA_W-1:0]      stbuf_wr_data,
   input  logic [`LSU_BYTE_W-1:0]      stbuf_wr_byteen,
   input  logic                        stbuf_drain,
   output logic                        dccm_rden,
   output logic [`LSU_DCCM_ADDR_W-1:0] dccm_rd_addr,
   output logic                        dccm_wren,
   output logic [`LSU_DCCM_ADDR_W-1:0] dccm_wr_addr,
   output logic [`LSU_DATA_W-1:0]      dccm_wr_data,
   output logic [`LSU_BYTE_W-1:0]      dccm_wr_byteen,
   output logic [`LSU_DATA_W-1:0]      lsu_result_dc3,
   output logic                        lsu_load_valid_dc3
);

   localparam int DW = `LSU_DATA_W;

   logic          ld_dc2;
   logic [DW-1:0] merged_dc2;
   logic [DW-1:0] shifted_dc2;
   logic [DW-1:0] ld_data_dc2;
   logic          sign_dc2;

   // ****************************
   // Port control
   // ****************************
   assign dccm_rden    = stage_dc1.pkt.valid & (stage_dc1.pkt.op == lsu_pkg::LSU_LOAD) &
                         stage_dc1.in_dccm & ~stage_dc1.misaligned;
   assign dccm_rd_addr = stage_dc1.addr[`LSU_DCCM_ADDR_W+1:2];   // Word address

   // Store buffer holds its drain back while a read owns the port
   assign dccm_wren      = stbuf_drain;
   assign dccm_wr_addr   = stbuf_wr_addr;
   assign dccm_wr_data   = stbuf_wr_data;
   assign dccm_wr_byteen = stbuf_wr_byteen;

   // ****************************
   // dc2 load data
   // ****************************
   assign ld_dc2 = stage_dc2.pkt.valid & (stage_dc2.pkt.op == lsu_pkg::LSU_LOAD) &
                   stage_dc2.in_dccm & ~stage_dc2.misaligned;

   // Buffered store bytes replace stale DCCM bytes
   always_comb begin
      for (int b = 0; b < `LSU_BYTE_W; b++) begin
         merged_dc2[8*b +: 8] = fwd_dc2.byteen[b] ? fwd_dc2.data[8*b +: 8]
                                                  : dccm_rd_data[8*b +: 8];
      end
   end

   assign shifted_dc2 = merged_dc2 >> {stage_dc2.addr[1:0], 3'b000};  // Byte lane to bit 0

   always_comb begin
      sign_dc2 = 1'b0;
      case (stage_dc2.pkt.size)
         lsu_pkg::SZ_BYTE: begin
            sign_dc2    = ~stage_dc2.pkt.unsign & shifted_dc2[7];
            ld_data_dc2 = {{(DW-8){sign_dc2}}, shifted_dc2[7:0]};
         end
         lsu_pkg::SZ_HALF: begin
            sign_dc2    = ~stage_dc2.pkt.unsign & shifted_dc2[15];
            ld_data_dc2 = {{(DW-16){sign_dc2}}, shifted_dc2[15:0]};
         end
         default:          ld_data_dc2 = shifted_dc2;               // Full word
      endcase
   end

   // ****************************
   // dc3 result
   // ****************************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         lsu_load_valid_dc3 <= 1'b0;
      end else begin
         lsu_load_valid_dc3 <= ld_dc2;                  // One cycle pulse per load
      end
   end

   always_ff @(posedge clk) begin
      if (ld_dc2) lsu_result_dc3 <= ld_data_dc2;
   end

   // A load read and a buffer drain never share the port
   a_port_single_use: assert property (@(posedge clk) disable iff (!arst_n)
      !(dccm_rden && dccm_wren));

endmodule

// ==== hw/lsu.sv ====
// ****************************
// Load store unit top
// ****************************

`timescale 1ns/100ps
`include "lsu_settings.svh"

module lsu (
   input  logic                        clk,
   input  logic                        arst_n,
   input  lsu_pkg::lsu_pkt_t           lsu_p,                 // Request, dc1
   input  logic [`LSU_DATA_W-1:0]      rs1,
   input  logic [11:0]                 offset,
   input  logic [`LSU_DATA_W-1:0]      store_data,
   input  logic [`LSU_DATA_W-1:0]      dccm_rd_data,
   output logic [`LSU_DATA_W-1:0]      lsu_result_dc3,
   output logic                        lsu_load_valid_dc3,
   output lsu_pkg::lsu_error_pkt_t     lsu_error_pkt_dc3,
   output logic                        lsu_pmu_misaligned_dc3,
   output logic                        lsu_store_stall_any,   // Hold off stores
   output logic                        lsu_idle_any,          // Pipe and buffer drained
   output logic                        dccm_rden,
   output logic                        dccm_wren,
   output logic [`LSU_DCCM_ADDR_W-1:0] dccm_rd_addr,
   output logic [`LSU_DCCM_ADDR_W-1:0] dccm_wr_addr,
   output logic [`LSU_DATA_W-1:0]      dccm_wr_data,
   output logic [`LSU_BYTE_W-1:0]      dccm_wr_byteen
);

   lsu_pkg::lsu_stage_t         stage_dc1;
   lsu_pkg::lsu_stage_t         stage_dc2;
   lsu_pkg::lsu_stage_t         stage_dc3;
   lsu_pkg::lsu_fwd_t           fwd_dc2;
   logic [`LSU_DCCM_ADDR_W-1:0] stbuf_wr_addr;
   logic [`LSU_DATA_W-1:0]      stbuf_wr_data;
   logic [`LSU_BYTE_W-1:0]      stbuf_wr_byteen;
   logic                        stbuf_drain;
   logic                        stbuf_empty;

   lsu_lsc_ctl lsc_ctl_inst (.*);
   lsu_stbuf stbuf_inst (.*);
   lsu_dccm_ctl dccm_ctl_inst (.*);

   // Nothing in flight and every store written
   assign lsu_idle_any = ~(stage_dc1.pkt.valid | stage_dc2.pkt.valid | stage_dc3.pkt.valid) &
                         stbuf_empty;

   assign lsu_pmu_misaligned_dc3 = stage_dc3.pkt.valid & stage_dc3.misaligned;

endmodule

// ==== tb/tb_lsu.sv ====
// ******************************
// LSU testbench
// ******************************

`timescale 1ns/100ps
`include "lsu_settings.svh"

module tb_lsu;

   localparam int DW         = `LSU_DATA_W;
   localparam int AW         = `LSU_DCCM_ADDR_W;
   localparam int WIN_LSB    = `LSU_DCCM_ADDR_W + 2;      // Lowest bit above the window
   localparam int DCCM_WORDS = 1 << `LSU_DCCM_ADDR_W;
   localparam int MAX_CYCLES = 2000;                      // All tests need about 400 cycles
   localparam logic [DW-1:0] DCCM_BASE = `LSU_DCCM_BASE;

   // Expected dc3 outcome of one request
   typedef struct packed {
      logic          st;                                  // Legal store, enters the buffer in dc2
      logic          ld;                                  // Load result due
      logic          exc;                                 // Error packet due
      logic [1:0]    exc_type;
      logic [DW-1:0] addr;
      logic [DW-1:0] data;
   } exp_t;

   logic                    clk = 1'b0;
   logic                    arst_n;
   lsu_pkg::lsu_pkt_t       lsu_p;
   logic [DW-1:0]           rs1;
   logic [11:0]             offset;
   logic [DW-1:0]           store_data;
   logic [DW-1:0]           dccm_rd_data = '0;
   logic [DW-1:0]           lsu_result_dc3;
   logic                    lsu_load_valid_dc3;
   lsu_pkg::lsu_error_pkt_t lsu_error_pkt_dc3;
   logic                    lsu_pmu_misaligned_dc3;
   logic                    lsu_store_stall_any;
   logic                    lsu_idle_any;
   logic                    dccm_rden;
   logic                    dccm_wren;
   logic [AW-1:0]           dccm_rd_addr;
   logic [AW-1:0]           dccm_wr_addr;
   logic [DW-1:0]           dccm_wr_data;
   logic [`LSU_BYTE_W-1:0]  dccm_wr_byteen;

   logic [DW-1:0] dccm_mem [DCCM_WORDS];                  // DCCM model contents
   logic [DW-1:0] ref_mem  [DCCM_WORDS];                  // Reference memory
   exp_t          nxt_exp = '0;                           // Request driven at the last edge
   exp_t          exp_dc1 = '0;
   exp_t          exp_dc2 = '0;
   exp_t          exp_dc3 = '0;
   int            stbuf_occ = 0;                          // Expected store buffer entries
   logic          alloc_due = 1'b0;                       // Entry added at the coming edge
   logic          drain_due = 1'b0;                       // Entry written this cycle
   logic          stall_seen = 1'b0;                      // Stall at the last falling edge
   integer        seed;
   int            cycle_count = 0;
   string         test_name = "reset";

   always #2 clk = ~clk;

   lsu lsu_inst (.*);

   // ******************************
   // DCCM model, 1 cycle read
   // ******************************
   always @(posedge clk) begin
      if (dccm_wren) begin
         for (int b = 0; b < `LSU_BYTE_W; b++) begin
            if (dccm_wr_byteen[b]) dccm_mem[dccm_wr_addr][8*b +: 8] <= dccm_wr_data[8*b +: 8];
         end
      end
      if (dccm_rden) dccm_rd_data <= dccm_mem[dccm_rd_addr];
   end

   // Run limit
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) report_fail("Timeout, the tests did not finish in time");
   end

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check(input string what, input logic [DW-1:0] expected,
                        input logic [DW-1:0] actual);
      if (expected !== actual) begin
         $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
         report_fail("Check mismatch");
      end
   endtask

   // ******************************
   // Expected values
   // ******************************
   function automatic logic [DW-1:0] fill_word(input int w);
      return (32'(w) * 32'h9E37_79B1) ^ 32'h5A5A_0000;    // Odd multiplier, unique per word
   endfunction

   function automatic logic [DW-1:0] dccm_addr(input int w, input int b);
      return DCCM_BASE + 32'(w * 4 + b);
   endfunction

   function automatic logic [DW-1:0] expected_load(input lsu_pkg::lsu_size_e size,
                                                   input logic uns, input logic [DW-1:0] addr);
      logic [DW-1:0] word;
      word = ref_mem[addr[WIN_LSB-1:2]] >> (8 * addr[1:0]);   // Addressed byte to lane 0
      case (size)
         lsu_pkg::SZ_BYTE: return {{(DW-8){~uns & word[7]}}, word[7:0]};
         lsu_pkg::SZ_HALF: return {{(DW-16){~uns & word[15]}}, word[15:0]};
         default:          return word;
      endcase
   endfunction

   function automatic void ref_store(input lsu_pkg::lsu_size_e size, input logic [DW-1:0] addr,
                                     input logic [DW-1:0] data);
      int         nbytes;
      int         n;
      logic [1:0] lane;
      nbytes = (size == lsu_pkg::SZ_BYTE) ? 1 : (size == lsu_pkg::SZ_HALF) ? 2 : 4;
      for (n = 0; n < nbytes; n++) begin
         lane = addr[1:0] + 2'(n);
         ref_mem[addr[WIN_LSB-1:2]][8*lane +: 8] = data[8*n +: 8];
      end
   endfunction

   // ******************************
   // Drive and monitor
   // ******************************
   task automatic issue(input lsu_pkg::lsu_op_e op, input lsu_pkg::lsu_size_e size,
                        input logic uns, input logic [DW-1:0] addr, input logic [DW-1:0] data);
      logic [11:0] off;
      logic        in_win;
      logic        mis;
      exp_t        e;
      off    = 12'($random(seed));
      in_win = addr[DW-1:WIN_LSB] == DCCM_BASE[DW-1:WIN_LSB];
      mis    = ((size == lsu_pkg::SZ_HALF) && addr[0]) ||
               ((size == lsu_pkg::SZ_WORD) && (addr[1:0] != 2'b00));
      e      = '0;
      e.addr = addr;
      if (mis || !in_win) begin
         e.exc      = 1'b1;
         e.exc_type = mis ? lsu_pkg::EXC_MISALIGNED : lsu_pkg::EXC_ACCESS;
      end else if (op == lsu_pkg::LSU_STORE) begin
         ref_store(size, addr, data);
         e.st = 1'b1;
      end else begin
         e.ld   = 1'b1;
         e.data = expected_load(size, uns, addr);
      end
      @(posedge clk);
      while ((op == lsu_pkg::LSU_STORE) && stall_seen) begin   // Hold the store back
         lsu_p   <= '0;
         nxt_exp = '0;
         @(posedge clk);
      end
      lsu_p      <= '{valid: 1'b1, op: op, size: size, unsign: uns};
      rs1        <= addr - {{20{off[11]}}, off};
      offset     <= off;
      store_data <= data;
      nxt_exp    = e;
   endtask

   task automatic store(input lsu_pkg::lsu_size_e size, input logic [DW-1:0] addr,
                        input logic [DW-1:0] data);
      issue(lsu_pkg::LSU_STORE, size, 1'b0, addr, data);
   endtask

   task automatic load(input lsu_pkg::lsu_size_e size, input logic uns, input logic [DW-1:0] addr);
      issue(lsu_pkg::LSU_LOAD, size, uns, addr, '0);
   endtask

   // Bubble, then wait for the pipe and the store buffer to empty
   task automatic drain_pipe();
      @(posedge clk);
      lsu_p   <= '0;
      nxt_exp = '0;
      do @(negedge clk); while (!lsu_idle_any);
   endtask

   task automatic compare_mem();
      for (int i = 0; i < DCCM_WORDS; i++) check($sformatf("dccm word %0d", i), ref_mem[i],
                                                 dccm_mem[i]);
   endtask

   // Pipeline of expectations, outputs sampled mid cycle
   always @(negedge clk) begin
      stall_seen = lsu_store_stall_any;
      if (arst_n) begin
         stbuf_occ = stbuf_occ + int'(alloc_due) - int'(drain_due);  // Edge that ended last cycle
         exp_dc3   = exp_dc2;
         exp_dc2   = exp_dc1;
         exp_dc1   = nxt_exp;
         alloc_due = exp_dc2.st;
         drain_due = (stbuf_occ != 0) && !exp_dc1.ld;     // Head goes out when no load reads
         check("dc1 read enable", exp_dc1.ld, dccm_rden);     // Errors never read
         check("drain write", drain_due, dccm_wren);
         check("store stall", (`LSU_STBUF_DEPTH - stbuf_occ) < 2, lsu_store_stall_any);
         check("load valid", exp_dc3.ld, lsu_load_valid_dc3);
         if (exp_dc3.ld) check("load data", exp_dc3.data, lsu_result_dc3);
         check("exc valid", exp_dc3.exc, lsu_error_pkt_dc3.exc_valid);
         if (exp_dc3.exc) begin
            check("exc type", exp_dc3.exc_type, lsu_error_pkt_dc3.exc_type);
            check("exc addr", exp_dc3.addr, lsu_error_pkt_dc3.addr);
         end
         check("pmu misaligned", exp_dc3.exc && (exp_dc3.exc_type == lsu_pkg::EXC_MISALIGNED),
               lsu_pmu_misaligned_dc3);
      end
   end

   // ******************************
   // Directed tests
   // ******************************
   task automatic round_trip();
      lsu_pkg::lsu_size_e sz;
      logic [DW-1:0]      addr;
      test_name = "round_trip";
      for (int s = 0; s < 3; s++) begin
         sz   = lsu_pkg::lsu_size_e'(s);
         addr = dccm_addr(16 + s, (s == 0) ? 3 : (s == 1) ? 2 : 0);
         store(sz, addr, $random(seed) | 32'h8080_8080);     // Sign bit set in every lane
         load(sz, 1'b0, addr);                               // Served by the store buffer
         load(sz, 1'b1, addr);
         drain_pipe();
         load(sz, 1'b0, addr);                               // Served by the DCCM
         load(sz, 1'b1, addr);
         store(sz, addr, $random(seed) & 32'h7F7F_7F7F);
         load(sz, 1'b0, addr);
      end
      drain_pipe();
   endtask

   task automatic forward_merge();
      test_name = "forward_merge";
      store(lsu_pkg::SZ_WORD, dccm_addr(40, 0), 32'h1122_3344);
      store(lsu_pkg::SZ_BYTE, dccm_addr(40, 1), 32'h0000_00AA);
      store(lsu_pkg::SZ_HALF, dccm_addr(40, 2), 32'h0000_BBCC);
      load(lsu_pkg::SZ_WORD, 1'b0, dccm_addr(40, 0));         // Newest bytes win
      load(lsu_pkg::SZ_HALF, 1'b1, dccm_addr(40, 2));
      load(lsu_pkg::SZ_BYTE, 1'b0, dccm_addr(40, 1));
      drain_pipe();
      store(lsu_pkg::SZ_BYTE, dccm_addr(40, 3), 32'h0000_0080); // Older bytes now in DCCM
      load(lsu_pkg::SZ_WORD, 1'b0, dccm_addr(40, 0));
      load(lsu_pkg::SZ_BYTE, 1'b0, dccm_addr(40, 3));
      store(lsu_pkg::SZ_HALF, dccm_addr(40, 0), 32'h0000_7F01);
      store(lsu_pkg::SZ_BYTE, dccm_addr(40, 1), 32'h0000_0055);
      load(lsu_pkg::SZ_HALF, 1'b0, dccm_addr(40, 0));
      load(lsu_pkg::SZ_WORD, 1'b0, dccm_addr(40, 0));
      drain_pipe();
      compare_mem();
   endtask

   task automatic misaligned_access();
      test_name = "misaligned_access";
      load(lsu_pkg::SZ_HALF, 1'b0, dccm_addr(50, 1));
      load(lsu_pkg::SZ_WORD, 1'b0, dccm_addr(50, 2));
      load(lsu_pkg::SZ_WORD, 1'b1, dccm_addr(50, 3));
      store(lsu_pkg::SZ_HALF, dccm_addr(50, 3), 32'hDEAD_BEEF);
      store(lsu_pkg::SZ_WORD, dccm_addr(51, 1), 32'hCAFE_F00D);
      load(lsu_pkg::SZ_WORD, 1'b0, dccm_addr(50, 0));         // Contents unchanged
      load(lsu_pkg::SZ_WORD, 1'b0, dccm_addr(51, 0));
      drain_pipe();
      compare_mem();
   endtask

   task automatic window_fault();
      test_name = "window_fault";
      load(lsu_pkg::SZ_WORD, 1'b0, 32'h1000_0040);
      store(lsu_pkg::SZ_WORD, DCCM_BASE + 32'h1000, 32'h1234_5678);  // Just above the window
      load(lsu_pkg::SZ_BYTE, 1'b1, DCCM_BASE - 32'd1);
      store(lsu_pkg::SZ_BYTE, 32'h0000_0100, 32'h0000_00FF);
      load(lsu_pkg::SZ_WORD, 1'b0, 32'h0000_0002);            // Misaligned takes priority
      drain_pipe();
      compare_mem();
   endtask

   task automatic store_burst();
      test_name = "store_burst";
      for (int i = 0; i < 12; i++) begin
         store(lsu_pkg::SZ_WORD, dccm_addr(64 + i, 0), $random(seed));
         store(lsu_pkg::SZ_BYTE, dccm_addr(64 + i, 2), $random(seed));
         load(lsu_pkg::SZ_WORD, 1'b0, dccm_addr(64 + i, 0));  // Loads hold off the drain
         load(lsu_pkg::SZ_HALF, 1'b1, dccm_addr(64 + i, 2));
      end
      drain_pipe();
      check("stall after drain", 1'b0, lsu_store_stall_any);
      compare_mem();
   endtask

   task automatic random_mix();
      logic [DW-1:0]      r;
      lsu_pkg::lsu_size_e sz;
      logic [DW-1:0]      addr;
      test_name = "random_mix";
      for (int n = 0; n < 200; n++) begin
         r    = $random(seed);
         sz   = (r[1:0] == 2'd3) ? lsu_pkg::SZ_WORD : lsu_pkg::lsu_size_e'(r[1:0]);
         addr = dccm_addr(96 + int'(r[6:4]), (sz == lsu_pkg::SZ_BYTE) ? int'(r[3:2]) :
                          (sz == lsu_pkg::SZ_HALF) ? int'({r[3], 1'b0}) : 0);
         if (r[7]) store(sz, addr, $random(seed));
         else      load(sz, r[8], addr);
      end
      drain_pipe();
      compare_mem();
   endtask

   task automatic check_reset_outputs();
      check("rden", 1'b0, dccm_rden);
      check("wren", 1'b0, dccm_wren);
      check("load valid", 1'b0, lsu_load_valid_dc3);
      check("exc valid", 1'b0, lsu_error_pkt_dc3.exc_valid);
      check("pmu misaligned", 1'b0, lsu_pmu_misaligned_dc3);
      check("store stall", 1'b0, lsu_store_stall_any);
      check("idle", 1'b1, lsu_idle_any);
   endtask

   initial begin
      seed       = 32'h5103_4990;
      arst_n     <= 1'b0;
      lsu_p      <= '0;
      rs1        <= '0;
      offset     <= '0;
      store_data <= '0;
      for (int i = 0; i < DCCM_WORDS; i++) begin
         dccm_mem[i] <= fill_word(i);
         ref_mem[i]  = fill_word(i);
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_reset_outputs();
      @(posedge clk);
      arst_n <= 1'b1;                                       // Released after 3 cycles
      round_trip();
      forward_merge();
      misaligned_access();
      window_fault();
      store_burst();
      random_mix();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+include
hw/lsu_pkg.sv
hw/lsu_lsc_ctl.sv
hw/lsu_stbuf.sv
hw/lsu_dccm_ctl.sv
hw/lsu.sv
tb/tb_lsu.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_lsu -o tb_lsu_sim
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

./obj_dir/tb_lsu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -F -q '*** PASSED ***' sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Pass message not found in sim.log"
   exit 1
fi
